// File: logic/adpcm_decoder.sv
// Time-multiplexed ADPCM decoder, serves one channel per cen and hands the sample to the mixer
`timescale 1ns/1ps
`default_nettype none
`include "adpcm_params.svh"

module adpcm_decoder (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             cen,      // one slot per strobe
    input  wire logic             cmd_stb,
    input  wire adpcm_pkg::cmd_u  cmd,
    output logic                  slot_stb, // one clock after cen
    output adpcm_pkg::slot_t      slot
);

    localparam int CH    = `ADPCM_CHANNELS;
    localparam int PCM_W = `ADPCM_PCM_W;
    localparam int ACC_W = `ADPCM_ACC_W;
    localparam int IDX_W = $clog2(`ADPCM_STEP_N);
    localparam int CH_W  = $clog2(CH);

    logic [CH_W-1:0]         slot_cnt;      // channel served at next cen
    logic signed [PCM_W-1:0] pred [CH];     // per-channel predictor
    logic [IDX_W-1:0]        idx [CH];      // per-channel step index
    adpcm_pkg::cmd_u         pend_cmd [CH]; // last write, code or control
    logic [CH-1:0]           pend_vld;

    adpcm_pkg::cmd_u         cur;
    logic [10:0]             step;
    logic [14:0]             prod;          // (2*mag+1)*step
    logic [11:0]             delta;
    logic signed [ACC_W-1:0] pred_ext;
    logic signed [ACC_W-1:0] sum_full;
    logic signed [4:0]       adj;
    logic signed [IDX_W:0]   idx_sum;
    logic signed [PCM_W-1:0] pred_nxt;
    logic [IDX_W-1:0]        idx_nxt;

    // decode for the channel of the current slot
    always_comb begin
        cur      = pend_cmd[slot_cnt];
        step     = adpcm_pkg::step_lookup(idx[slot_cnt]);
        prod     = 15'({cur.code.mag, 1'b1}) * 15'(step);
        delta    = prod[14:3];                                   // >>3
        pred_ext = $signed({{(ACC_W-PCM_W){pred[slot_cnt][PCM_W-1]}}, pred[slot_cnt]});
        sum_full = cur.code.sign ? pred_ext - $signed(ACC_W'(delta))
                                 : pred_ext + $signed(ACC_W'(delta));
        adj      = adpcm_pkg::index_adjust(cur.code.mag);
        idx_sum  = $signed({1'b0, idx[slot_cnt]}) + adj;         // may leave 0..48
        pred_nxt = pred[slot_cnt];                               // hold by default
        idx_nxt  = idx[slot_cnt];
        if (pend_vld[slot_cnt]) begin
            if (cur.ctrl.is_ctrl) begin
                if (cur.ctrl.key_on) begin
                    pred_nxt = '0;                               // restart channel
                    idx_nxt  = '0;
                end
            end else begin
                pred_nxt = adpcm_pkg::sat_pcm(sum_full);
                if (idx_sum < 0)
                    idx_nxt = '0;                                // clamp low
                else if (idx_sum > (IDX_W+1)'(`ADPCM_STEP_N - 1))
                    idx_nxt = IDX_W'(`ADPCM_STEP_N - 1);          // clamp high
                else
                    idx_nxt = idx_sum[IDX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt <= '0;
            slot_stb <= 1'b0;
            slot     <= '0;
            pend_vld <= '0;
            for (int i = 0; i < CH; i++) begin
                pred[i] <= '0;
                idx[i]  <= '0;
            end
        end else begin
            slot_stb <= cen;
            if (cen) begin
                slot_cnt           <= (slot_cnt == CH_W'(CH - 1)) ? '0 : slot_cnt + 1'b1;
                slot.ch            <= slot_cnt;
                slot.pcm           <= pred_nxt;                  // value after update
                pred[slot_cnt]     <= pred_nxt;
                idx[slot_cnt]      <= idx_nxt;
                pend_vld[slot_cnt] <= 1'b0;                      // consumed
            end
            if (cmd_stb)
                pend_vld[cmd.code.ch] <= 1'b1;                   // same-cycle write wins
        end
    end

    // command payload, qualified by pend_vld
    always_ff @(posedge clk) begin
        if (cmd_stb)
            pend_cmd[cmd.code.ch] <= cmd; // replaces an older write
    end

    a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
        slot_cnt <= CH_W'(CH - 1));

    a_cmd_ch_range: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_stb |-> cmd.code.ch <= CH_W'(CH - 1));

endmodule

`default_nettype wire

// File: logic/adpcm_frame_acc.sv
// Frame accumulator, sums the channel samples and latches frame sum and interpolation step
`timescale 1ns/1ps
`default_nettype none
`include "adpcm_params.svh"

module adpcm_frame_acc (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              slot_stb,
    input  wire adpcm_pkg::slot_t  slot,
    output logic                   frame_stb, // after channel 0
    output logic                   sub_stb,   // after channels 1..5
    output adpcm_pkg::mix_t        mix
);

    localparam int CH    = `ADPCM_CHANNELS;
    localparam int PCM_W = `ADPCM_PCM_W;
    localparam int ACC_W = `ADPCM_ACC_W;
    localparam int CH_W  = $clog2(CH);

    logic signed [ACC_W-1:0]   pcm_ext;
    logic signed [ACC_W-1:0]   acc, last, step;
    logic signed [ACC_W-1:0]   diff;
    logic signed [ACC_W+4:0]   diff_ext, step_full; // room for x43
    logic [CH_W-1:0]           prev_ch;
    logic                      ch0;

    assign ch0     = (slot.ch == '0);
    assign pcm_ext = $signed({{(ACC_W-PCM_W){slot.pcm[PCM_W-1]}}, slot.pcm});

    // step = diff * (1/4 + 1/16 + 1/64 + 1/128)
    always_comb begin
        diff      = acc - last;                           // new sum minus old
        diff_ext  = $signed({{5{diff[ACC_W-1]}}, diff});
        step_full = diff_ext + (diff_ext <<< 1) + (diff_ext <<< 3) + (diff_ext <<< 5);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            last      <= '0;
            step      <= '0;
            frame_stb <= 1'b0;
            sub_stb   <= 1'b0;
            prev_ch   <= CH_W'(CH - 1); // first slot is channel 0
        end else begin
            frame_stb <= slot_stb && ch0;
            sub_stb   <= slot_stb && !ch0;
            if (slot_stb) begin
                prev_ch <= slot.ch;
                acc     <= ch0 ? pcm_ext : acc + pcm_ext; // restart at channel 0
                if (ch0) begin
                    last <= acc;                          // full previous frame
                    step <= ACC_W'(step_full >>> 7);
                end
            end
        end
    end

    assign mix.sum  = last;
    assign mix.step = step;

    a_frame_order: assert property (@(posedge clk) disable iff (!rst_n)
        slot_stb && ch0 |-> prev_ch == CH_W'(CH - 1));

endmodule

`default_nettype wire

// File: logic/adpcm_interp.sv
// Interpolator, outputs three saturated samples per frame stepping up from the frame sum
`timescale 1ns/1ps
`default_nettype none
`include "adpcm_params.svh"

module adpcm_interp (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             frame_stb,
    input  wire logic             sub_stb,
    input  wire adpcm_pkg::mix_t  mix,
    output logic                  out_stb,   // one clock after trigger
    output adpcm_pkg::pcm_out_t   pcm
);

    localparam int ACC_W = `ADPCM_ACC_W;
    localparam int CH_W  = $clog2(`ADPCM_CHANNELS);

    logic signed [ACC_W-1:0] run;      // running interpolated value
    logic signed [ACC_W-1:0] run_nxt;
    logic [CH_W-1:0]         sub_cnt;  // sub_stb seen since frame_stb
    logic [CH_W-1:0]         sub_nxt;
    logic                    emit_sub; // slots 2 and 4

    assign run_nxt  = run + mix.step;
    assign sub_nxt  = sub_cnt + 1'b1;
    assign emit_sub = sub_stb && (sub_nxt == CH_W'(2) || sub_nxt == CH_W'(4));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run     <= '0;
            sub_cnt <= '0;
            out_stb <= 1'b0;
            pcm     <= '0;
        end else begin
            out_stb <= frame_stb || emit_sub;
            if (frame_stb) begin
                run             <= mix.sum;
                sub_cnt         <= '0;           // restart count
                pcm.frame_start <= 1'b1;
                pcm.sample      <= adpcm_pkg::sat_pcm(mix.sum);
            end else if (sub_stb) begin
                sub_cnt <= sub_nxt;
                if (emit_sub) begin
                    run             <= run_nxt;  // one step further
                    pcm.frame_start <= 1'b0;
                    pcm.sample      <= adpcm_pkg::sat_pcm(run_nxt);
                end
            end
        end
    end

    a_stb_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(frame_stb && sub_stb));

endmodule

`default_nettype wire

// File: logic/adpcm_mixer_top.sv
// Top level of the six-channel ADPCM mixer, decoder into accumulator into interpolator
`timescale 1ns/1ps
`default_nettype none

module adpcm_mixer_top (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             cen,     // slot strobe
    input  wire logic             cmd_stb, // host write strobe
    input  wire adpcm_pkg::cmd_u  cmd,
    output logic                  out_stb,
    output adpcm_pkg::pcm_out_t   pcm
);

    logic             slot_stb;
    adpcm_pkg::slot_t slot;      // channel and decoded sample
    logic             frame_stb;
    logic             sub_stb;
    adpcm_pkg::mix_t  mix;       // frame sum and step

    adpcm_decoder i_adpcm_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .cmd_stb  (cmd_stb),
        .cmd      (cmd),
        .slot_stb (slot_stb),
        .slot     (slot)
    );

    adpcm_frame_acc i_adpcm_frame_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .slot_stb  (slot_stb),
        .slot      (slot),
        .frame_stb (frame_stb),
        .sub_stb   (sub_stb),
        .mix       (mix)
    );

    adpcm_interp i_adpcm_interp (
        .clk       (clk),
        .rst_n     (rst_n),
        .frame_stb (frame_stb),
        .sub_stb   (sub_stb),
        .mix       (mix),
        .out_stb   (out_stb),
        .pcm       (pcm)
    );

endmodule

`default_nettype wire

// File: logic/adpcm_params.svh
// Size constants for the ADPCM mixer, included by the package and every RTL file that sizes logic
`ifndef ADPCM_PARAMS_SVH
`define ADPCM_PARAMS_SVH

// time slots per frame, one per channel
`define ADPCM_CHANNELS 6

// decoded sample width, signed
`define ADPCM_PCM_W 16

// frame accumulator width, signed
`define ADPCM_ACC_W 18

// entries in the ADPCM step table
`define ADPCM_STEP_N 49

`endif

// File: logic/adpcm_pkg.sv
// Shared types and lookup functions for the ADPCM mixer, referenced by scoped names
`default_nettype none
`include "adpcm_params.svh"

package adpcm_pkg;

    // host command word, code view
    typedef struct packed {
        logic       is_ctrl; // 0 for a code write
        logic [2:0] ch;
        logic       sign;    // 1 subtracts the delta
        logic [2:0] mag;
    } cmd_code_t;

    // host command word, control view
    typedef struct packed {
        logic       is_ctrl; // 1 for a control write
        logic [2:0] ch;
        logic       key_on;  // clears predictor and index
        logic [2:0] rsvd;
    } cmd_ctrl_t;

    typedef union packed {
        cmd_code_t code;
        cmd_ctrl_t ctrl;
    } cmd_u;

    // decoder to accumulator
    typedef struct packed {
        logic [$clog2(`ADPCM_CHANNELS)-1:0] ch;
        logic signed [`ADPCM_PCM_W-1:0]     pcm;
    } slot_t;

    // accumulator to interpolator
    typedef struct packed {
        logic signed [`ADPCM_ACC_W-1:0] sum;  // last full frame sum
        logic signed [`ADPCM_ACC_W-1:0] step; // about a third of the frame change
    } mix_t;

    typedef struct packed {
        logic                           frame_start;
        logic signed [`ADPCM_PCM_W-1:0] sample;
    } pcm_out_t;

    localparam logic [10:0] STEP_TAB [`ADPCM_STEP_N] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    function automatic logic [10:0] step_lookup(input logic [5:0] idx);
        if (idx > 6'(`ADPCM_STEP_N - 1)) return STEP_TAB[`ADPCM_STEP_N - 1]; // top entry
        return STEP_TAB[idx];
    endfunction

    // -1 for small codes, then 2, 4, 6, 8
    function automatic logic signed [4:0] index_adjust(input logic [2:0] mag);
        if (mag < 3'd4) return -5'sd1;
        return $signed({1'b0, mag - 3'd3, 1'b0}); // (mag-3)*2
    endfunction

    // clip an accumulator-wide value into the sample range
    function automatic logic signed [`ADPCM_PCM_W-1:0] sat_pcm(
        input logic signed [`ADPCM_ACC_W-1:0] v
    );
        logic [`ADPCM_ACC_W-`ADPCM_PCM_W:0] top;
        top = v[`ADPCM_ACC_W-1:`ADPCM_PCM_W-1];                 // sign plus guard bits
        if (&top || ~|top) return v[`ADPCM_PCM_W-1:0];          // in range
        return v[`ADPCM_ACC_W-1] ? {1'b1, {(`ADPCM_PCM_W-1){1'b0}}}  // -32768
                                 : {1'b0, {(`ADPCM_PCM_W-1){1'b1}}}; // +32767
    endfunction

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the ADPCM mixer testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module adpcm_tb \
    -f tb.f -o adpcm_sim > build.log 2>&1 \
    && ./obj_dir/adpcm_sim > "$LOG" 2>&1 \
    || { echo "build or simulation error"; cat build.log; exit 1; }

cat "$LOG"
grep -q "tests failed" "$LOG" \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// File: tb.f
+incdir+logic
+incdir+verification
logic/adpcm_pkg.sv
logic/adpcm_decoder.sv
logic/adpcm_frame_acc.sv
logic/adpcm_interp.sv
logic/adpcm_mixer_top.sv
verification/adpcm_tb.sv

// File: verification/adpcm_model.svh
// Reference model of the ADPCM decoder and mixer, included inside the testbench module
`ifndef ADPCM_MODEL_SVH
`define ADPCM_MODEL_SVH
`include "adpcm_params.svh"

// standard ADPCM step sizes, index 0..48
localparam int STEP_SIZES [`ADPCM_STEP_N] = '{
    16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
    80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307, 337,
    371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166, 1282, 1411, 1552
};

int              m_pred [`ADPCM_CHANNELS]; // predictor per channel
int              m_idx  [`ADPCM_CHANNELS]; // step index per channel
adpcm_pkg::cmd_u m_pend [`ADPCM_CHANNELS]; // newest write wins
bit              m_vld  [`ADPCM_CHANNELS];

function automatic int clip(input int v, input int lo, input int hi);
    if (v < lo) return lo;
    if (v > hi) return hi;
    return v;
endfunction

function automatic void reset_channels();
    for (int i = 0; i < `ADPCM_CHANNELS; i++) begin
        m_pred[i] = 0;
        m_idx[i]  = 0;
        m_vld[i]  = 1'b0;
    end
endfunction

function automatic void queue_command(input adpcm_pkg::cmd_u c);
    m_pend[c.code.ch] = c; // replaces an older write
    m_vld[c.code.ch]  = 1'b1;
endfunction

// every channel reaches its slot once per frame
function automatic void apply_pending();
    adpcm_pkg::cmd_u c;
    int              mag;
    int              delta;
    for (int i = 0; i < `ADPCM_CHANNELS; i++) begin
        c = m_pend[i];
        if (m_vld[i] && c.ctrl.is_ctrl) begin
            if (c.ctrl.key_on) begin
                m_pred[i] = 0; // channel restarts silent
                m_idx[i]  = 0;
            end
        end else if (m_vld[i]) begin
            mag       = int'(c.code.mag);
            delta     = ((2 * mag + 1) * STEP_SIZES[m_idx[i]]) / 8;
            m_pred[i] = clip(c.code.sign ? m_pred[i] - delta : m_pred[i] + delta,
                             -32768, 32767);
            m_idx[i]  = clip(m_idx[i] + ((mag < 4) ? -1 : 2 * (mag - 3)), 0, 48);
        end
        m_vld[i] = 1'b0;
    end
endfunction

function automatic int channel_sum();
    int s;
    s = 0;
    for (int i = 0; i < `ADPCM_CHANNELS; i++) s += m_pred[i];
    return s;
endfunction

// k-th in-between sample, step is 43/128 of the frame change
function automatic int mid_sample(input int prev, input int cur, input int k);
    int step;
    step = ((cur - prev) * 43) >>> 7; // floor, like an arithmetic shift
    return clip(cur + k * step, -32768, 32767);
endfunction

// a clipped frame sample hides the true sum
function automatic bit at_rail(input int v);
    return (v == 32767) || (v == -32768);
endfunction

`endif

// File: verification/adpcm_tb.sv
// Testbench for the ADPCM mixer, applies a command table and checks frame and in-between samples
`timescale 1ns/1ps
`default_nettype none
`include "adpcm_params.svh"

module adpcm_tb;

    localparam int CLK_NS    = 4;
    localparam int RST_CLK   = 10;
    localparam int FRAME_CLK = `ADPCM_CHANNELS * 8; // six slots, cen every 8 clocks
    localparam int N_ROWS    = 24;

    // commands go out left to right, cmd[0] first
    typedef struct packed {
        logic [3:0]            n;   // commands used
        logic [3:0]            rnd; // 1 draws random codes per channel
        adpcm_pkg::cmd_u [0:5] cmd;
    } row_t;

    // n | rnd | cmd0..cmd5, cmd = is_ctrl, ch[2:0], sign or key_on, mag[2:0]
    localparam row_t ROWS [N_ROWS] = '{
        56'h10_01_00_00_00_00_00, // ch0 +1, index stays at 0
        56'h10_0A_00_00_00_00_00, // ch0 -2, clamps low again
        56'h10_07_00_00_00_00_00,
        56'h10_07_00_00_00_00_00,
        56'h10_0E_00_00_00_00_00, // ch0 -6
        56'h60_03_13_23_33_43_53, // all channels together
        56'h60_0D_1D_2D_3D_4D_5D,
        56'h10_A8_00_00_00_00_00, // key_on ch2 only
        56'h61_00_00_00_00_00_00, // random codes
        56'h61_00_00_00_00_00_00,
        56'h60_88_98_A8_B8_C8_D8, // key_on everywhere
        56'h60_07_17_27_37_47_57, // climb toward +32767
        56'h60_07_17_27_37_47_57,
        56'h60_07_17_27_37_47_57,
        56'h60_07_17_27_37_47_57,
        56'h60_07_17_27_37_47_57,
        56'h60_07_17_27_37_47_57,
        56'h60_07_17_27_37_47_57, // index clamps at 48
        56'h60_07_17_27_37_47_57, // sum past the rail
        56'h60_0F_1F_2F_3F_4F_5F, // fall toward -32768
        56'h60_0F_1F_2F_3F_4F_5F,
        56'h60_0F_1F_2F_3F_4F_5F,
        56'h60_0F_1F_2F_3F_4F_5F,
        56'h60_0F_1F_2F_3F_4F_5F
    };

    logic                clk;
    logic                rst_n;
    logic                cen;
    logic                cmd_stb;
    adpcm_pkg::cmd_u     cmd;
    logic                out_stb;
    adpcm_pkg::pcm_out_t pcm;

    int n_errors = 0;
    int n_checks = 0;
    bit cen_seen = 1'b0;
    bit fs_seen  = 1'b0; // a frame start has gone by
    int fs_prev  = 0;  // frame samples after reset are zero
    int fs_cur   = 0;
    int sub_k    = 0;  // in-between samples this frame

    `include "adpcm_model.svh"

    adpcm_mixer_top i_adpcm_mixer_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .cmd_stb (cmd_stb),
        .cmd     (cmd),
        .out_stb (out_stb),
        .pcm     (pcm)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // cen one clock in eight once reset is released
    initial begin
        cen = 1'b0;
        @(posedge rst_n);
        forever begin
            repeat (7) @(posedge clk);
            cen <= 1'b1;
            @(posedge clk);
            cen <= 1'b0;
        end
    end

    task automatic check_pcm(input adpcm_pkg::pcm_out_t got, input adpcm_pkg::pcm_out_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("Error at %0d ns: pcm got {%0b, %0d}, expected {%0b, %0d}",
                     $time, got.frame_start, got.sample, want.frame_start, want.sample);
        end
    endtask

    task automatic check_interp(input adpcm_pkg::pcm_out_t got, input adpcm_pkg::pcm_out_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("Error at %0d ns: pcm.sample (sub %0d) got {%0b, %0d}, expected {%0b, %0d}",
                     $time, sub_k, got.frame_start, got.sample, want.frame_start, want.sample);
        end
    endtask

    task automatic wait_frame_start();
        @(posedge clk);
        while (!(out_stb && pcm.frame_start)) @(posedge clk);
    endtask

    // output monitor, follows every out_stb
    always @(posedge clk) begin
        adpcm_pkg::pcm_out_t want_mid;
        if (out_stb && !cen_seen) begin
            n_errors++;
            $display("out_stb went high at %0d ns before any cen", $time);
        end
        if (cen) cen_seen = 1'b1;
        if (out_stb && pcm.frame_start) begin
            if (fs_seen && sub_k < 2) begin
                n_errors++;
                $display("frame ending at %0d ns had %0d in-between samples instead of two",
                         $time, sub_k);
            end
            fs_seen = 1'b1;
            fs_prev = fs_cur;
            fs_cur  = int'(pcm.sample);
            sub_k   = 0;
        end else if (out_stb) begin
            sub_k++;
            if (sub_k > 2) begin
                n_errors++;
                $display("more than two in-between samples in one frame at %0d ns", $time);
            end else if (!at_rail(fs_prev) && !at_rail(fs_cur)) begin
                want_mid.frame_start = 1'b0;
                want_mid.sample      = 16'(mid_sample(fs_prev, fs_cur, sub_k));
                check_interp(pcm, want_mid);
            end
        end
    end

    initial begin
        row_t                row;
        adpcm_pkg::pcm_out_t want;
        rst_n   = 1'b0;
        cmd_stb = 1'b0;
        cmd     = '0;
        void'($urandom(56));
        reset_channels();
        repeat (RST_CLK) @(posedge clk);
        rst_n <= 1'b1;
        wait_frame_start(); // first frame is silent
        want.frame_start = 1'b1;
        want.sample      = '0;
        check_pcm(pcm, want);
        for (int r = 0; r < N_ROWS; r++) begin
            row = ROWS[r];
            wait_frame_start();
            for (int i = 0; i < int'(row.n); i++) begin
                if (row.rnd != 4'd0)
                    row.cmd[i] = {1'b0, 3'(i), 4'($urandom_range(15, 0))};
                cmd_stb <= 1'b1;
                cmd     <= row.cmd[i];
                queue_command(row.cmd[i]);
                @(posedge clk);
            end
            cmd_stb <= 1'b0;
            apply_pending();
            repeat (4) wait_frame_start(); // settled by now
            want.sample = 16'(clip(channel_sum(), -32768, 32767));
            check_pcm(pcm, want);
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // five frames per row, plus reset and a few frames of slack
    initial begin
        #((N_ROWS * 5 * FRAME_CLK + RST_CLK + 4 * FRAME_CLK) * CLK_NS);
        $display("timeout, the run did not reach its end");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
